/* flist.f */
src/nocPkg.sv
src/grantTimer.sv
src/flitFifo.sv
src/outputArbiter.sv
src/outputStage.sv
src/routerOutputPort.sv
verif/routerOutputPortTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module routerOutputPortTb -o simv

simOutput=$(./obj_dir/simv || true)
echo "$simOutput"

if echo "$simOutput" | grep -q "All checks passed"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* verif/routerOutputPortTb.sv */
`timescale 1ns/10ps

module routerOutputPortTb;

  localparam int TIMEOUT_CYCLES = 5000;

  logic                          clk;
  logic                          rst;
  logic                          inValid [nocPkg::NUM_PORTS];
  nocPkg::flitT                  inFlit [nocPkg::NUM_PORTS];
  logic [nocPkg::NUM_PORTS-1:0]  inReady; // Bit 0 is L, bit 4 is S.
  logic                          outValid;
  nocPkg::flitT                  outFlit;
  logic                          outReady;

  nocPkg::flitT expQ [$];
  nocPkg::flitT gotQ [$];
  nocPkg::flitT pktL [$];
  nocPkg::flitT pktN [$];
  nocPkg::flitT pktE [$];
  nocPkg::flitT pktW [$];
  nocPkg::flitT pktS [$];
  int           cycleCount;

  routerOutputPort #(.FIFO_DEPTH(4)) routerOutputPort_inst
  (
    .clk      (clk),
    .rst      (rst),
    .inValidL (inValid[0]),
    .inReadyL (inReady[0]),
    .inFlitL  (inFlit[0]),
    .inValidN (inValid[1]),
    .inReadyN (inReady[1]),
    .inFlitN  (inFlit[1]),
    .inValidE (inValid[2]),
    .inReadyE (inReady[2]),
    .inFlitE  (inFlit[2]),
    .inValidW (inValid[3]),
    .inReadyW (inReady[3]),
    .inFlitW  (inFlit[3]),
    .inValidS (inValid[4]),
    .inReadyS (inReady[4]),
    .inFlitS  (inFlit[4]),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks failed");
    $fatal(1);
  end

  task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      $display("mismatch %s exp=%h got=%h", name, exp, got);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // Header carries the length and the last flit is a tail.
  task automatic makePacket(input int len, output nocPkg::flitT pkt [$]);
    nocPkg::flitKindT kind;
    pkt = {};
    pkt.push_back({nocPkg::KIND_HEAD, 1'b0, nocPkg::lengthT'(len)});
    for (int i = 1; i < len; i++)
    begin
      kind = (i == len - 1) ? nocPkg::KIND_TAIL : nocPkg::KIND_BODY;
      pkt.push_back({kind, 13'($urandom)});
    end
  endtask

  task automatic appendPacket(input nocPkg::flitT pkt [$]);
    foreach (pkt[i])
      expQ.push_back(pkt[i]);
  endtask

  task automatic sendPacket(input int port, input nocPkg::flitT pkt [$]);
    int idx;
    idx = 0;
    while (idx < pkt.size())
    begin
      @(posedge clk);
      inValid[port] <= 1'b1;
      inFlit[port]  <= pkt[idx];
      @(negedge clk);
      if (inReady[port])
        idx++; // Taken on the coming edge.
    end
    @(posedge clk);
    inValid[port] <= 1'b0;
  endtask

  // Also checks that a stalled flit holds still.
  task automatic collectOutput(input int count, input bit gaps);
    logic         stalled;
    nocPkg::flitT heldFlit;
    stalled  = 1'b0;
    heldFlit = '0;
    gotQ     = {};
    while (gotQ.size() < count)
    begin
      @(posedge clk);
      outReady <= gaps ? ($urandom_range(3) != 0) : 1'b1;
      @(negedge clk);
      if (stalled)
      begin
        checkEq("outValid", 32'(1), 32'(outValid));
        checkEq("outFlit", 32'(heldFlit), 32'(outFlit));
      end
      stalled  = outValid & ~outReady;
      heldFlit = outFlit;
      if (outValid && outReady)
        gotQ.push_back(outFlit);
    end
  endtask

  task automatic compareOutput();
    foreach (expQ[i])
      checkEq($sformatf("outFlit[%0d]", i), 32'(expQ[i]), 32'(gotQ[i]));
    repeat (3)
    begin
      @(negedge clk);
      checkEq("outValid", 32'(0), 32'(outValid)); // No flit beyond the last packet.
    end
  endtask

  task automatic checkResetState();
    @(negedge clk);
    checkEq("outValid", 32'(0), 32'(outValid));
    checkEq("inReady", 32'h1f, 32'(inReady));
  endtask

  task automatic streamSinglePacket();
    nocPkg::flitT pkt [$];
    makePacket(6, pkt);
    expQ = {};
    appendPacket(pkt);
    fork
      sendPacket(1, pkt);
      collectOutput(expQ.size(), 1'b0);
    join
    compareOutput();
  endtask

  // All ports start together, so L wins and rotation gives N, E, W, S.
  task automatic runAllPorts(input bit gaps);
    expQ = {};
    appendPacket(pktL);
    appendPacket(pktN);
    appendPacket(pktE);
    appendPacket(pktW);
    appendPacket(pktS);
    fork
      sendPacket(0, pktL);
      sendPacket(1, pktN);
      sendPacket(2, pktE);
      sendPacket(3, pktW);
      sendPacket(4, pktS);
      collectOutput(expQ.size(), gaps);
    join
    compareOutput();
  endtask

  task automatic drainAllPorts();
    makePacket(2, pktL);
    makePacket(5, pktN);
    makePacket(3, pktE);
    makePacket(6, pktW);
    makePacket(4, pktS);
    runAllPorts(1'b0);
  endtask

  task automatic rotateAfterHolder();
    nocPkg::flitT eastPkt [$];
    nocPkg::flitT localPkt [$];
    nocPkg::flitT southPkt [$];
    makePacket(3, eastPkt);
    makePacket(2, localPkt);
    makePacket(2, southPkt);
    @(posedge clk);
    outReady <= 1'b0; // Stall so E keeps the grant.
    sendPacket(2, eastPkt);
    do
      @(negedge clk);
    while (!outValid);
    fork
      sendPacket(0, localPkt);
      sendPacket(4, southPkt);
    join
    expQ = {};
    appendPacket(eastPkt);
    appendPacket(southPkt);
    appendPacket(localPkt);
    collectOutput(expQ.size(), 1'b0);
    compareOutput();
  endtask

  task automatic stallWithGaps();
    runAllPorts(1'b1); // Same packets as the no-gap run.
  endtask

  initial
  begin
    void'($urandom(32'h8150f8c0));
    rst      = 1'b1;
    outReady = 1'b0;
    for (int i = 0; i < nocPkg::NUM_PORTS; i++)
    begin
      inValid[i] = 1'b0;
      inFlit[i]  = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    checkResetState();
    streamSinglePacket();
    drainAllPorts();
    rotateAfterHolder();
    stallWithGaps();
    $display("All checks passed");
    $finish;
  end

endmodule

/* src/routerOutputPort.sv */
`timescale 1ns/10ps

module routerOutputPort
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic         clk,
  input  logic         rst,
  input  logic         inValidL,
  output logic         inReadyL,
  input  nocPkg::flitT inFlitL,
  input  logic         inValidN,
  output logic         inReadyN,
  input  nocPkg::flitT inFlitN,
  input  logic         inValidE,
  output logic         inReadyE,
  input  nocPkg::flitT inFlitE,
  input  logic         inValidW,
  output logic         inReadyW,
  input  nocPkg::flitT inFlitW,
  input  logic         inValidS,
  output logic         inReadyS,
  input  nocPkg::flitT inFlitS,
  output logic         outValid,
  output nocPkg::flitT outFlit,
  input  logic         outReady
);

  nocPkg::flitT                  headFlitL;
  nocPkg::flitT                  headFlitN;
  nocPkg::flitT                  headFlitE;
  nocPkg::flitT                  headFlitW;
  nocPkg::flitT                  headFlitS;
  logic [nocPkg::NUM_PORTS-1:0]  notEmpty; // Bit 0 is L, bit 4 is S.
  logic [nocPkg::NUM_PORTS-1:0]  pop;
  logic [nocPkg::NUM_PORTS-1:0]  gnt;
  logic                          xfer;
  nocPkg::flitT                  xferFlit;

  flitFifo #(.FIFO_DEPTH(FIFO_DEPTH)) flitFifoL_inst
  (
    .clk(clk), .rst(rst), .inValid(inValidL), .inReady(inReadyL), .inFlit(inFlitL),
    .pop(pop[0]), .headFlit(headFlitL), .notEmpty(notEmpty[0])
  );

  flitFifo #(.FIFO_DEPTH(FIFO_DEPTH)) flitFifoN_inst
  (
    .clk(clk), .rst(rst), .inValid(inValidN), .inReady(inReadyN), .inFlit(inFlitN),
    .pop(pop[1]), .headFlit(headFlitN), .notEmpty(notEmpty[1])
  );

  flitFifo #(.FIFO_DEPTH(FIFO_DEPTH)) flitFifoE_inst
  (
    .clk(clk), .rst(rst), .inValid(inValidE), .inReady(inReadyE), .inFlit(inFlitE),
    .pop(pop[2]), .headFlit(headFlitE), .notEmpty(notEmpty[2])
  );

  flitFifo #(.FIFO_DEPTH(FIFO_DEPTH)) flitFifoW_inst
  (
    .clk(clk), .rst(rst), .inValid(inValidW), .inReady(inReadyW), .inFlit(inFlitW),
    .pop(pop[3]), .headFlit(headFlitW), .notEmpty(notEmpty[3])
  );

  flitFifo #(.FIFO_DEPTH(FIFO_DEPTH)) flitFifoS_inst
  (
    .clk(clk), .rst(rst), .inValid(inValidS), .inReady(inReadyS), .inFlit(inFlitS),
    .pop(pop[4]), .headFlit(headFlitS), .notEmpty(notEmpty[4])
  );

  outputArbiter outputArbiter_inst
  (
    .clk      (clk),
    .rst      (rst),
    .req      (notEmpty),
    .xfer     (xfer),
    .xferFlit (xferFlit),
    .gnt      (gnt)
  );

  outputStage outputStage_inst
  (
    .clk       (clk),
    .rst       (rst),
    .gnt       (gnt),
    .headFlit0 (headFlitL),
    .headFlit1 (headFlitN),
    .headFlit2 (headFlitE),
    .headFlit3 (headFlitW),
    .headFlit4 (headFlitS),
    .notEmpty  (notEmpty),
    .pop       (pop),
    .xfer      (xfer),
    .xferFlit  (xferFlit),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outReady  (outReady)
  );

endmodule

/* src/outputStage.sv */
`timescale 1ns/10ps

module outputStage
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [nocPkg::NUM_PORTS-1:0]  gnt,
  input  nocPkg::flitT                  headFlit0,
  input  nocPkg::flitT                  headFlit1,
  input  nocPkg::flitT                  headFlit2,
  input  nocPkg::flitT                  headFlit3,
  input  nocPkg::flitT                  headFlit4,
  input  logic [nocPkg::NUM_PORTS-1:0]  notEmpty,
  output logic [nocPkg::NUM_PORTS-1:0]  pop,
  output logic                          xfer,
  output nocPkg::flitT                  xferFlit,
  output logic                          outValid,
  output nocPkg::flitT                  outFlit,
  input  logic                          outReady
);

  nocPkg::portIdxT gntIdx;
  logic            regFree;

  always_comb
  begin
    gntIdx = '0;
    for (int i = 0; i < nocPkg::NUM_PORTS; i++)
      if (gnt[i])
        gntIdx = nocPkg::portIdxT'(i);
  end

  always_comb
  begin
    case (gntIdx)
      3'd0:    xferFlit = headFlit0;
      3'd1:    xferFlit = headFlit1;
      3'd2:    xferFlit = headFlit2;
      3'd3:    xferFlit = headFlit3;
      default: xferFlit = headFlit4;
    endcase
  end

  assign regFree = ~outValid | outReady; // Empty or draining.
  assign pop     = gnt & notEmpty & {nocPkg::NUM_PORTS{regFree}};
  assign xfer    = |pop;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (xfer)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (xfer)
      outFlit <= xferFlit; // Held while stalled.
  end

endmodule

/* src/outputArbiter.sv */
`timescale 1ns/10ps

module outputArbiter
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [nocPkg::NUM_PORTS-1:0]  req,
  input  logic                          xfer,
  input  nocPkg::flitT                  xferFlit,
  output logic [nocPkg::NUM_PORTS-1:0]  gnt
);

  nocPkg::arbStateT              state;
  nocPkg::arbStateT              nextState;
  logic [nocPkg::NUM_PORTS-1:0]  gntNext;
  nocPkg::flitKindT              xferKind;
  nocPkg::lengthT                xferLength;
  logic                          isHead;
  logic [nocPkg::NUM_PORTS-1:0]  load;
  logic [nocPkg::NUM_PORTS-1:0]  count;
  logic [nocPkg::NUM_PORTS-1:0]  clear;
  logic [nocPkg::NUM_PORTS-1:0]  timesUp;
  logic                          holderDone;

  // First requester in rotation order, scanning span ports from start.
  function automatic nocPkg::arbStateT pickFrom(input logic [nocPkg::NUM_PORTS-1:0] reqIn,
                                                input int start, input int span);
    int p;
    pickFrom = nocPkg::ARB_IDLE;
    for (int k = span - 1; k >= 0; k--)
    begin
      p = (start + k) % nocPkg::NUM_PORTS;
      if (reqIn[p])
        pickFrom = nocPkg::arbStateT'(p + 1);
    end
  endfunction

  assign xferKind   = xferFlit[nocPkg::KIND_MSB:nocPkg::KIND_LSB];
  assign xferLength = xferFlit[nocPkg::LENGTH_MSB:0];
  assign isHead     = (xferKind == nocPkg::KIND_HEAD);

  for (genvar i = 0; i < nocPkg::NUM_PORTS; i++)
  begin : genTimer
    assign load[i]  = gnt[i] & xfer & isHead;
    assign count[i] = gnt[i] & xfer & ~isHead;
    assign clear[i] = gnt[i] & xfer & timesUp[i]; // Last flit of the packet.

    grantTimer grantTimer_inst
    (
      .clk        (clk),
      .rst        (rst),
      .load       (load[i]),
      .loadLength (xferLength),
      .count      (count[i]),
      .clear      (clear[i]),
      .timesUp    (timesUp[i])
    );
  end

  assign holderDone = |clear;

  // Holder keeps the grant until its packet is out, then the next port leads.
  always_comb
  begin
    nextState = state;
    case (state)
      nocPkg::ARB_IDLE: nextState = pickFrom(req, 0, nocPkg::NUM_PORTS);
      nocPkg::ARB_L:
        if (holderDone)
          nextState = pickFrom(req, 1, nocPkg::NUM_PORTS - 1);
      nocPkg::ARB_N:
        if (holderDone)
          nextState = pickFrom(req, 2, nocPkg::NUM_PORTS - 1);
      nocPkg::ARB_E:
        if (holderDone)
          nextState = pickFrom(req, 3, nocPkg::NUM_PORTS - 1);
      nocPkg::ARB_W:
        if (holderDone)
          nextState = pickFrom(req, 4, nocPkg::NUM_PORTS - 1);
      nocPkg::ARB_S:
        if (holderDone)
          nextState = pickFrom(req, 0, nocPkg::NUM_PORTS - 1);
      default: nextState = nocPkg::ARB_IDLE;
    endcase
  end

  always_comb
  begin
    gntNext = '0;
    if (nextState != nocPkg::ARB_IDLE)
      gntNext[nocPkg::portIdxT'(nextState) - 3'd1] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::ARB_IDLE;
      gnt   <= '0;
    end
    else
    begin
      state <= nextState;
      gnt   <= gntNext; // One-hot copy of the state.
    end
  end

endmodule

/* src/flitFifo.sv */
`timescale 1ns/10ps

module flitFifo
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic         clk,
  input  logic         rst,
  input  logic         inValid,
  output logic         inReady,
  input  nocPkg::flitT inFlit,
  input  logic         pop,
  output nocPkg::flitT headFlit,
  output logic         notEmpty
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

  nocPkg::flitT     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0]   occupancy;
  logic             wrEn;
  logic             rdEn;

  assign inReady  = (occupancy != FULL_COUNT);
  assign notEmpty = (occupancy != '0);
  assign headFlit = mem[rdPtr];

  assign wrEn = inValid & inReady;
  assign rdEn = pop & notEmpty;

  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr] <= inFlit;
  end

  // Pointers wrap on their own, depth is a power of two.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      occupancy <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= wrPtr + 1'b1;
      if (rdEn)
        rdPtr <= rdPtr + 1'b1;
      case ({wrEn, rdEn})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy; // Both or neither.
      endcase
    end
  end

endmodule

/* src/grantTimer.sv */
`timescale 1ns/10ps

module grantTimer
(
  input  logic           clk,
  input  logic           rst,
  input  logic           load,
  input  nocPkg::lengthT loadLength,
  input  logic           count,
  input  logic           clear,
  output logic           timesUp
);

  nocPkg::lengthT cnt;
  nocPkg::lengthT length;
  nocPkg::lengthT nextCnt;
  nocPkg::lengthT nextLength;

  // Lookahead so the last flit's transfer sees timesUp.
  always_comb
  begin
    nextLength = load ? loadLength : length;
    if (load)
      nextCnt = nocPkg::lengthT'(1); // Header counts as one.
    else if (count)
      nextCnt = cnt + nocPkg::lengthT'(1);
    else
      nextCnt = cnt;
  end

  assign timesUp = (nextCnt == nextLength);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt    <= '0;
      length <= '0;
    end
    else
    begin
      if (load)
        length <= loadLength;
      if (clear)
        cnt <= '0; // Grant ends.
      else
        cnt <= nextCnt;
    end
  end

endmodule

/* src/nocPkg.sv */
package nocPkg;

  // One flit on a link. Kind in bits 15..13, payload below.
  typedef logic [15:0] flitT;

  typedef logic [2:0] flitKindT;

  localparam flitKindT KIND_HEAD = 3'b001;
  localparam flitKindT KIND_BODY = 3'b010;
  localparam flitKindT KIND_TAIL = 3'b100;

  localparam int KIND_MSB = 15;
  localparam int KIND_LSB = 13;

  // Packet length in flits, header included.
  typedef logic [11:0] lengthT;

  localparam int LENGTH_MSB = 11;

  typedef logic [2:0] portIdxT;

  // L, N, E, W, S in that order.
  localparam int NUM_PORTS = 5;

  typedef enum logic [2:0]
  {
    ARB_IDLE,
    ARB_L,
    ARB_N,
    ARB_E,
    ARB_W,
    ARB_S
  } arbStateT;

endpackage
